//--- common/dtpu_arith_pkg.sv
`default_nettype none

package dtpu_arith_pkg;

  ////////////////////////////////////////////////////////////
  // Element precision
  ////////////////////////////////////////////////////////////

  // Selected by bit 0 of the precision CSR byte
  typedef enum logic [0:0] {
    PREC_INT8 = 1'b0,
    PREC_INT4 = 1'b1
  } precision_t;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Lane pitch in input and weight words, both precisions
  localparam int MAX_ELEM_WIDTH = 8;
  // Used part of a lane in 4-bit mode
  localparam int INT4_WIDTH     = 4;
  // Full signed product of two lanes
  localparam int PROD_WIDTH     = 2 * MAX_ELEM_WIDTH;
  // One result lane in the output word
  localparam int ACC_WIDTH      = 20;

  // Lane to signed element, 4-bit mode keeps only the low nibble
  function automatic logic signed [MAX_ELEM_WIDTH-1:0] lane_ext(
    input logic [MAX_ELEM_WIDTH-1:0] lane,
    input precision_t                prec
  );
    logic signed [MAX_ELEM_WIDTH-1:0] ext;
    if (prec == PREC_INT4) begin
      ext = {{(MAX_ELEM_WIDTH - INT4_WIDTH){lane[INT4_WIDTH-1]}}, lane[INT4_WIDTH-1:0]};
    end else begin
      ext = lane;
    end
    return ext;
  endfunction

endpackage

`default_nettype wire

//--- common/dtpu_ctrl_pkg.sv
`default_nettype none

package dtpu_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // CSR map
  ////////////////////////////////////////////////////////////

  // Byte addresses in the CSR block RAM
  localparam logic [31:0] CSR_ADDR_PREC  = 32'd0;
  localparam logic [31:0] CSR_ADDR_COUNT = 32'd1;

  ////////////////////////////////////////////////////////////
  // Control unit
  ////////////////////////////////////////////////////////////

  // Run sequence, one pass per start
  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    CSR_RD = 3'd1,
    W_LOAD = 3'd2,
    STREAM = 3'd3,
    DRAIN  = 3'd4,
    DONE   = 3'd5
  } cu_state_t;

  // Control unit to matrix array
  typedef struct packed {
    // Whole pipeline moves
    logic                      advance;
    // Input word taken this cycle
    logic                      in_valid;
    // Weight word on the bus is valid
    logic                      w_load;
    // Destination weight row
    logic [3:0]                w_row;
    // Element precision of the run
    dtpu_arith_pkg::precision_t prec;
  } mxu_ctrl_t;

endpackage

`default_nettype wire

//--- mxu/mxu_row_dot.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_row_dot #(
  parameter int COLUMNS = 3
) (
  input  logic                                                    clk,
  input  logic                                                    rst_n,
  input  logic                                                    advance,
  input  dtpu_arith_pkg::precision_t                              prec,
  input  logic [COLUMNS*dtpu_arith_pkg::MAX_ELEM_WIDTH-1:0]       weights,
  input  logic [COLUMNS*dtpu_arith_pkg::MAX_ELEM_WIDTH-1:0]       inputs,
  output logic signed [dtpu_arith_pkg::ACC_WIDTH-1:0]             sum
);

  localparam int EW = dtpu_arith_pkg::MAX_ELEM_WIDTH;
  localparam int PW = dtpu_arith_pkg::PROD_WIDTH;
  localparam int AW = dtpu_arith_pkg::ACC_WIDTH;

  logic signed [PW-1:0] prod_d [COLUMNS];
  logic signed [PW-1:0] prod_q [COLUMNS];
  logic signed [AW-1:0] sum_d;
  logic signed [AW-1:0] sum_q;

  ////////////////////////////////////////////////////////////
  // Stage 1 lane products
  ////////////////////////////////////////////////////////////

  // Sign extension per precision, then full signed multiply
  always_comb begin
    for (int c = 0; c < COLUMNS; c++) begin
      prod_d[c] = dtpu_arith_pkg::lane_ext(weights[c*EW +: EW], prec) *
                  dtpu_arith_pkg::lane_ext(inputs[c*EW +: EW], prec);
    end
  end

  // Frozen while back-pressured
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < COLUMNS; c++) begin
        prod_q[c] <= '0;
      end
    end else if (advance) begin
      for (int c = 0; c < COLUMNS; c++) begin
        prod_q[c] <= prod_d[c];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2 reduction
  ////////////////////////////////////////////////////////////

  // Products widened to the lane width before the add
  always_comb begin
    sum_d = '0;
    for (int c = 0; c < COLUMNS; c++) begin
      sum_d = sum_d + {{(AW - PW){prod_q[c][PW-1]}}, prod_q[c]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_q <= '0;
    end else if (advance) begin
      sum_q <= sum_d;
    end
  end

  assign sum = sum_q;

endmodule

`default_nettype wire

//--- mxu/mxu_array.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_array #(
  parameter int ROWS    = 3,
  parameter int COLUMNS = 3
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  dtpu_ctrl_pkg::mxu_ctrl_t mxu_ctrl,
  input  logic [63:0]             weight_word,
  input  logic [63:0]             input_word,
  output logic                    res_valid,
  output logic [63:0]             res_word
);

  localparam int EW     = dtpu_arith_pkg::MAX_ELEM_WIDTH;
  localparam int AW     = dtpu_arith_pkg::ACC_WIDTH;
  localparam int ROW_W  = COLUMNS * EW;

  // Weight rows, lane c of row r is element c
  logic [ROW_W-1:0]     w_rows_q [ROWS];
  // Per-row results out of stage 2
  logic signed [AW-1:0] row_sum  [ROWS];
  // Valid alongside stage 1 and stage 2
  logic                 valid_s1_q;
  logic                 valid_s2_q;

  ////////////////////////////////////////////////////////////
  // Weight storage and row engines
  ////////////////////////////////////////////////////////////

  for (genvar r = 0; r < ROWS; r++) begin : g_row
    // Row r filled only when selected
    always_ff @(posedge clk) begin
      if (mxu_ctrl.w_load && (mxu_ctrl.w_row == 4'(r))) begin
        w_rows_q[r] <= weight_word[ROW_W-1:0];
      end
    end

    mxu_row_dot #(
      .COLUMNS (COLUMNS)
    ) i_row_dot (
      .clk     (clk),
      .rst_n   (rst_n),
      .advance (mxu_ctrl.advance),
      .prec    (mxu_ctrl.prec),
      .weights (w_rows_q[r]),
      .inputs  (input_word[ROW_W-1:0]),
      .sum     (row_sum[r])
    );
  end

  ////////////////////////////////////////////////////////////
  // Valid pipeline
  ////////////////////////////////////////////////////////////

  // Moves in step with the row engines
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_s1_q <= 1'b0;
      valid_s2_q <= 1'b0;
    end else if (mxu_ctrl.advance) begin
      valid_s1_q <= mxu_ctrl.in_valid;
      valid_s2_q <= valid_s1_q;
    end
  end

  // Result leaves only on an advancing cycle
  assign res_valid = valid_s2_q && mxu_ctrl.advance;

  // Lane r holds row r, unused upper bits zero
  always_comb begin
    res_word = '0;
    for (int r = 0; r < ROWS; r++) begin
      res_word[r*AW +: AW] = row_sum[r];
    end
  end

  // Control unit addresses only existing rows
  assert property (@(posedge clk) disable iff (!rst_n)
    mxu_ctrl.w_load |-> (int'(mxu_ctrl.w_row) < ROWS))
    else $error("weight row %0d out of range", mxu_ctrl.w_row);

endmodule

`default_nettype wire

//--- control/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit #(
  parameter int ROWS = 3
) (
  input  logic                     clk,
  input  logic                     rst_n,
  // CSR block RAM
  output logic [31:0]              csr_address,
  output logic                     csr_ce,
  input  logic [7:0]               csr_dout,
  // Weight block RAM
  output logic [31:0]              wm_address,
  output logic                     wm_ce,
  // Input FIFO
  input  logic                     infifo_is_empty,
  output logic                     infifo_read,
  // Output FIFO
  input  logic                     outfifo_is_full,
  input  logic                     res_valid,
  // Start/done handshake
  input  logic                     cs_start,
  input  logic                     cs_continue,
  output logic                     cs_ready,
  output logic                     cs_done,
  output logic                     cs_idle,
  // Matrix array control
  output dtpu_ctrl_pkg::mxu_ctrl_t mxu_ctrl
);

  // Last step of the weight load, data of the final row arrives
  localparam logic [4:0] LAST_STEP = 5'(ROWS);

  dtpu_ctrl_pkg::cu_state_t   state_q;
  // Sub-step inside CSR_RD and W_LOAD
  logic [4:0]                 step_q;
  dtpu_arith_pkg::precision_t prec_q;
  // Vectors in this run
  logic [7:0]                 count_q;
  // Vectors taken from the input FIFO
  logic [7:0]                 issued_q;
  // Results pushed to the output FIFO
  logic [7:0]                 written_q;
  // Ready for a run with no vectors
  logic                       zero_pulse_q;
  logic                       issue_last;
  logic                       write_last;

  ////////////////////////////////////////////////////////////
  // Outputs per state
  ////////////////////////////////////////////////////////////

  always_comb begin
    csr_ce        = 1'b0;
    csr_address   = '0;
    wm_ce         = 1'b0;
    wm_address    = '0;
    mxu_ctrl      = '0;
    mxu_ctrl.prec = prec_q;
    case (state_q)
      dtpu_ctrl_pkg::CSR_RD: begin
        // Step 2 only collects the count byte
        csr_ce      = (step_q != 5'd2);
        csr_address = (step_q == 5'd0) ? dtpu_ctrl_pkg::CSR_ADDR_PREC
                                        : dtpu_ctrl_pkg::CSR_ADDR_COUNT;
      end
      dtpu_ctrl_pkg::W_LOAD: begin
        // Read row step, store row step-1 from last cycle's read
        wm_ce           = (step_q != LAST_STEP);
        wm_address      = {27'd0, step_q};
        mxu_ctrl.w_load = (step_q != 5'd0);
        mxu_ctrl.w_row  = step_q[3:0] - 4'd1;
      end
      dtpu_ctrl_pkg::STREAM: begin
        mxu_ctrl.advance  = !outfifo_is_full;
        mxu_ctrl.in_valid = !outfifo_is_full && !infifo_is_empty &&
                            (issued_q != count_q);
      end
      dtpu_ctrl_pkg::DRAIN: begin
        // Flush in-flight vectors, no new input
        mxu_ctrl.advance = !outfifo_is_full;
      end
      default: begin
      end
    endcase
  end

  assign infifo_read = mxu_ctrl.in_valid;
  assign issue_last  = mxu_ctrl.in_valid && (issued_q == count_q - 8'd1);
  assign write_last  = res_valid && (written_q == count_q - 8'd1);

  // Last read, or entry to DONE on an empty run
  assign cs_ready = issue_last || zero_pulse_q;
  assign cs_done  = (state_q == dtpu_ctrl_pkg::DONE);
  assign cs_idle  = (state_q == dtpu_ctrl_pkg::IDLE);

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= dtpu_ctrl_pkg::IDLE;
      step_q       <= '0;
      prec_q       <= dtpu_arith_pkg::PREC_INT8;
      count_q      <= '0;
      issued_q     <= '0;
      written_q    <= '0;
      zero_pulse_q <= 1'b0;
    end else begin
      zero_pulse_q <= 1'b0;
      case (state_q)
        dtpu_ctrl_pkg::IDLE: begin
          if (cs_start) begin
            state_q <= dtpu_ctrl_pkg::CSR_RD;
            step_q  <= '0;
          end
        end
        dtpu_ctrl_pkg::CSR_RD: begin
          step_q <= step_q + 5'd1;
          // Precision byte back one cycle after its read
          if (step_q == 5'd1) begin
            prec_q <= dtpu_arith_pkg::precision_t'(csr_dout[0]);
          end
          if (step_q == 5'd2) begin
            count_q   <= csr_dout;
            issued_q  <= '0;
            written_q <= '0;
            step_q    <= '0;
            // Empty run skips weights and streaming
            if (csr_dout == 8'd0) begin
              state_q      <= dtpu_ctrl_pkg::DONE;
              zero_pulse_q <= 1'b1;
            end else begin
              state_q <= dtpu_ctrl_pkg::W_LOAD;
            end
          end
        end
        dtpu_ctrl_pkg::W_LOAD: begin
          step_q <= step_q + 5'd1;
          if (step_q == LAST_STEP) begin
            state_q <= dtpu_ctrl_pkg::STREAM;
          end
        end
        dtpu_ctrl_pkg::STREAM: begin
          if (mxu_ctrl.in_valid) begin
            issued_q <= issued_q + 8'd1;
          end
          if (res_valid) begin
            written_q <= written_q + 8'd1;
          end
          if (issue_last) begin
            state_q <= dtpu_ctrl_pkg::DRAIN;
          end
        end
        dtpu_ctrl_pkg::DRAIN: begin
          if (res_valid) begin
            written_q <= written_q + 8'd1;
          end
          if (write_last) begin
            state_q <= dtpu_ctrl_pkg::DONE;
          end
        end
        dtpu_ctrl_pkg::DONE: begin
          if (cs_continue) begin
            state_q <= dtpu_ctrl_pkg::IDLE;
          end
        end
        default: begin
          state_q <= dtpu_ctrl_pkg::IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // FWFT contract towards the input FIFO
  assert property (@(posedge clk) disable iff (!rst_n)
    infifo_read |-> !infifo_is_empty)
    else $error("input FIFO read while empty");

  // Done only once every issued vector has left the matrix array
  assert property (@(posedge clk) disable iff (!rst_n)
    cs_done |-> (written_q == count_q) && (issued_q == written_q) && !res_valid)
    else $error("done with results outstanding");

endmodule

`default_nettype wire

//--- rtl/dtpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module dtpu_core #(
  parameter int ROWS    = 3,
  parameter int COLUMNS = 3
) (
  input  logic        clk,
  input  logic        rst_n,
  // CSR block RAM, read only
  output logic [31:0] csr_address,
  output logic        csr_ce,
  input  logic [7:0]  csr_dout,
  // Weight block RAM, read only
  output logic [31:0] wm_address,
  output logic        wm_ce,
  input  logic [63:0] wm_dout,
  // Input FIFO, first word fall through
  input  logic        infifo_is_empty,
  input  logic [63:0] infifo_dout,
  output logic        infifo_read,
  // Output FIFO
  input  logic        outfifo_is_full,
  output logic [63:0] outfifo_din,
  output logic        outfifo_write,
  // Accelerator handshake
  input  logic        cs_start,
  input  logic        cs_continue,
  output logic        cs_ready,
  output logic        cs_done,
  output logic        cs_idle
);

  dtpu_ctrl_pkg::mxu_ctrl_t mxu_ctrl;
  // Result leaving stage 2, also counted by the control unit
  logic                     res_valid;

  ////////////////////////////////////////////////////////////
  // Control unit
  ////////////////////////////////////////////////////////////

  control_unit #(
    .ROWS (ROWS)
  ) i_control_unit (
    .clk             (clk),
    .rst_n           (rst_n),
    .csr_address     (csr_address),
    .csr_ce          (csr_ce),
    .csr_dout        (csr_dout),
    .wm_address      (wm_address),
    .wm_ce           (wm_ce),
    .infifo_is_empty (infifo_is_empty),
    .infifo_read     (infifo_read),
    .outfifo_is_full (outfifo_is_full),
    .res_valid       (res_valid),
    .cs_start        (cs_start),
    .cs_continue     (cs_continue),
    .cs_ready        (cs_ready),
    .cs_done         (cs_done),
    .cs_idle         (cs_idle),
    .mxu_ctrl        (mxu_ctrl)
  );

  ////////////////////////////////////////////////////////////
  // Matrix unit
  ////////////////////////////////////////////////////////////

  // RAM and FIFO data go straight in, qualified by mxu_ctrl
  mxu_array #(
    .ROWS    (ROWS),
    .COLUMNS (COLUMNS)
  ) i_mxu_array (
    .clk         (clk),
    .rst_n       (rst_n),
    .mxu_ctrl    (mxu_ctrl),
    .weight_word (wm_dout),
    .input_word  (infifo_dout),
    .res_valid   (res_valid),
    .res_word    (outfifo_din)
  );

  assign outfifo_write = res_valid;

  // Back-pressure path through both blocks
  assert property (@(posedge clk) disable iff (!rst_n)
    outfifo_write |-> !outfifo_is_full)
    else $error("output FIFO write while full");

endmodule

`default_nettype wire

//--- tb/dtpu_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dtpu_core_tb;

  localparam int ROWS      = 3;
  localparam int COLUMNS   = 3;
  localparam int AW        = 20;
  localparam int NUM_RUNS  = 6;
  localparam int DONE_WAIT = 2000;

  // One accelerator run per table row
  typedef struct packed {
    logic       prec;
    logic [7:0] count;
    logic [6:0] in_stall;
    logic [6:0] out_stall;
    // Path through W_LOAD and STREAM, else straight to DONE
    logic       streams;
  } run_t;

  // DUT outputs and FIFO flags as seen mid-cycle
  typedef struct packed {
    logic        csr_ce;
    logic [31:0] csr_address;
    logic        wm_ce;
    logic [31:0] wm_address;
    logic        infifo_read;
    logic        infifo_is_empty;
    logic        outfifo_write;
    logic        outfifo_is_full;
    logic [63:0] outfifo_din;
    logic        cs_ready;
    logic        cs_done;
    logic        cs_idle;
  } snap_t;

  logic        clk;
  logic        rst_n;
  logic [31:0] csr_address;
  logic        csr_ce;
  logic [7:0]  csr_dout;
  logic [31:0] wm_address;
  logic        wm_ce;
  logic [63:0] wm_dout;
  logic        infifo_is_empty;
  logic [63:0] infifo_dout;
  logic        infifo_read;
  logic        outfifo_is_full;
  logic [63:0] outfifo_din;
  logic        outfifo_write;
  logic        cs_start;
  logic        cs_continue;
  logic        cs_ready;
  logic        cs_done;
  logic        cs_idle;

  // RAM contents and FIFO queues
  logic [7:0]  csr_mem [4];
  logic [63:0] wm_mem [16];
  logic [63:0] in_q [$];
  logic [63:0] exp_q [$];
  run_t        runs [NUM_RUNS];
  run_t        cur;
  snap_t       seen;
  logic [31:0] rng_state;
  // Traffic of the current run
  int          in_reads;
  int          out_writes;
  int          wm_reads;
  int          ready_pulses;

  dtpu_core #(
    .ROWS    (ROWS),
    .COLUMNS (COLUMNS)
  ) i_dtpu_core (
    .clk             (clk),
    .rst_n           (rst_n),
    .csr_address     (csr_address),
    .csr_ce          (csr_ce),
    .csr_dout        (csr_dout),
    .wm_address      (wm_address),
    .wm_ce           (wm_ce),
    .wm_dout         (wm_dout),
    .infifo_is_empty (infifo_is_empty),
    .infifo_dout     (infifo_dout),
    .infifo_read     (infifo_read),
    .outfifo_is_full (outfifo_is_full),
    .outfifo_din     (outfifo_din),
    .outfifo_write   (outfifo_write),
    .cs_start        (cs_start),
    .cs_continue     (cs_continue),
    .cs_ready        (cs_ready),
    .cs_done         (cs_done),
    .cs_idle         (cs_idle)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi, lo};
  endfunction

  // Signed lane value where 4-bit mode reads only the low nibble
  function automatic int elem_value(input logic [7:0] lane, input logic prec);
    int v;
    if (prec) begin
      v = int'(lane[3:0]);
      if (lane[3]) begin
        v = v - 16;
      end
    end else begin
      v = int'(lane);
      if (lane[7]) begin
        v = v - 256;
      end
    end
    return v;
  endfunction

  // Lane r holds row r dot input and upper bits stay zero
  function automatic logic [63:0] expected_word(input logic [63:0] x, input logic prec);
    logic [63:0] word;
    int          acc;
    word = '0;
    for (int r = 0; r < ROWS; r++) begin
      acc = 0;
      for (int c = 0; c < COLUMNS; c++) begin
        acc += elem_value(wm_mem[r][c*8 +: 8], prec) * elem_value(x[c*8 +: 8], prec);
      end
      word[r*AW +: AW] = acc[AW-1:0];
    end
    return word;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks and cycle stepping
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Effects of the edge just passed, then new FIFO flags
  task automatic update_models();
    if (seen.csr_ce) begin
      csr_dout = csr_mem[seen.csr_address[1:0]];
    end
    if (seen.wm_ce) begin
      wm_dout = wm_mem[seen.wm_address[3:0]];
      wm_reads++;
    end
    if (seen.infifo_read) begin
      check_value("infifo_is_empty", seen.infifo_is_empty, 1'b0);
      in_reads++;
      void'(in_q.pop_front());
    end
    if (seen.outfifo_write) begin
      check_value("outfifo_is_full", seen.outfifo_is_full, 1'b0);
      out_writes++;
      if (exp_q.size() == 0) begin
        fail_run("Output word written with no result expected");
      end
      check_value("outfifo_din", seen.outfifo_din, exp_q.pop_front());
    end
    if (seen.cs_ready) begin
      ready_pulses++;
    end
    // FWFT view with random starvation
    if (in_q.size() != 0 && (next_rand() % 100) >= cur.in_stall) begin
      infifo_is_empty = 1'b0;
      infifo_dout     = in_q[0];
    end else begin
      infifo_is_empty = 1'b1;
      infifo_dout     = '0;
    end
    outfifo_is_full = (next_rand() % 100) < cur.out_stall;
  endtask

  // Sample mid-cycle, drive 1 ns after the edge
  task automatic step();
    @(negedge clk);
    seen.csr_ce          = csr_ce;
    seen.csr_address     = csr_address;
    seen.wm_ce           = wm_ce;
    seen.wm_address      = wm_address;
    seen.infifo_read     = infifo_read;
    seen.infifo_is_empty = infifo_is_empty;
    seen.outfifo_write   = outfifo_write;
    seen.outfifo_is_full = outfifo_is_full;
    seen.outfifo_din     = outfifo_din;
    seen.cs_ready        = cs_ready;
    seen.cs_done         = cs_done;
    seen.cs_idle         = cs_idle;
    @(posedge clk);
    #1;
    update_models();
  endtask

  ////////////////////////////////////////////////////////////
  // One run from the table
  ////////////////////////////////////////////////////////////

  task automatic do_run(input int idx, input run_t run);
    logic [63:0] x;
    logic [31:0] junk;
    int          cycles;
    cur = run;
    in_q.delete();
    exp_q.delete();
    in_reads     = 0;
    out_writes   = 0;
    wm_reads     = 0;
    ready_pulses = 0;
    // Only bit 0 of the precision byte counts
    junk       = next_rand();
    csr_mem[0] = {junk[6:0], run.prec};
    csr_mem[1] = run.count;
    for (int r = 0; r < 16; r++) begin
      wm_mem[r] = rand64();
    end
    for (int v = 0; v < int'(run.count); v++) begin
      x = rand64();
      in_q.push_back(x);
      exp_q.push_back(expected_word(x, run.prec));
    end
    // Decoys that an empty run must leave alone
    if (!run.streams) begin
      in_q.push_back(rand64());
      in_q.push_back(rand64());
    end
    cs_start = 1'b1;
    step();
    cs_start = 1'b0;
    // Start taken in IDLE
    check_value("cs_idle", seen.cs_idle, 1'b1);
    cycles = 0;
    while (!seen.cs_done) begin
      step();
      cycles++;
      check_value("cs_idle", seen.cs_idle, 1'b0);
      if (cycles > DONE_WAIT) begin
        fail_run("Timeout while waiting for cs_done");
      end
    end
    check_value("output count", out_writes, run.count);
    check_value("cs_ready pulses", ready_pulses, 1);
    if (run.streams) begin
      check_value("weight reads", wm_reads, ROWS);
      check_value("input reads", in_reads, run.count);
    end else begin
      check_value("weight reads", wm_reads, 0);
      check_value("input reads", in_reads, 0);
    end
    // Done holds until continue
    repeat (3) begin
      step();
      check_value("cs_done", seen.cs_done, 1'b1);
    end
    cs_continue = 1'b1;
    step();
    cs_continue = 1'b0;
    step();
    check_value("cs_idle", seen.cs_idle, 1'b1);
    check_value("cs_done", seen.cs_done, 1'b0);
    check_value("cs_ready pulses", ready_pulses, 1);
    $display("run %0d finished, %0d vectors in %0d cycles", idx, run.count, cycles);
  endtask

  initial begin
    rng_state       = 32'd99011;
    cur             = '0;
    seen            = '0;
    rst_n           = 1'b0;
    cs_start        = 1'b0;
    cs_continue     = 1'b0;
    csr_dout        = '0;
    wm_dout         = '0;
    infifo_is_empty = 1'b1;
    infifo_dout     = '0;
    outfifo_is_full = 1'b0;
    // Plain int8, plain int4, back-pressure, starvation, empty, mixed
    runs[0] = '{prec: 1'b0, count: 8'd12, in_stall: 7'd0,  out_stall: 7'd0,  streams: 1'b1};
    runs[1] = '{prec: 1'b1, count: 8'd12, in_stall: 7'd0,  out_stall: 7'd0,  streams: 1'b1};
    runs[2] = '{prec: 1'b0, count: 8'd20, in_stall: 7'd0,  out_stall: 7'd50, streams: 1'b1};
    runs[3] = '{prec: 1'b1, count: 8'd20, in_stall: 7'd50, out_stall: 7'd0,  streams: 1'b1};
    runs[4] = '{prec: 1'b0, count: 8'd0,  in_stall: 7'd0,  out_stall: 7'd0,  streams: 1'b0};
    runs[5] = '{prec: 1'b1, count: 8'd16, in_stall: 7'd30, out_stall: 7'd30, streams: 1'b1};
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step();
    // Quiet outputs out of reset
    check_value("cs_idle", seen.cs_idle, 1'b1);
    check_value("cs_done", seen.cs_done, 1'b0);
    check_value("cs_ready", seen.cs_ready, 1'b0);
    check_value("csr_ce", seen.csr_ce, 1'b0);
    check_value("wm_ce", seen.wm_ce, 1'b0);
    check_value("infifo_read", seen.infifo_read, 1'b0);
    check_value("outfifo_write", seen.outfifo_write, 1'b0);
    for (int i = 0; i < NUM_RUNS; i++) begin
      do_run(i, runs[i]);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dtpu_core.f
common/dtpu_arith_pkg.sv
common/dtpu_ctrl_pkg.sv
mxu/mxu_row_dot.sv
mxu/mxu_array.sv
control/control_unit.sv
rtl/dtpu_core.sv
tb/dtpu_core_tb.sv

//--- run.sh
#!/bin/sh
# Build the dtpu_core testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module dtpu_core_tb \
  -f dtpu_core.f -o dtpu_core_sim > build.log 2>&1 \
  && ./obj_dir/dtpu_core_sim > sim.log 2>&1 \
  || echo "build or simulation ended with an error, see build.log and sim.log"

grep -qx "TEST PASSED" sim.log 2>/dev/null \
  && echo "simulation passed" && exit 0
echo "simulation failed"
exit 1
